/* hdl/tone_pkg.sv */
// Tone generator types
`default_nettype none

package tone_pkg;

    typedef logic [7:0] sample_t;      // Unsigned audio sample
    typedef logic [5:0] note_t;        // Octave * 12 + semitone

    typedef enum logic [1:0] {
        wave_tri = 2'd0,
        wave_saw = 2'd1,
        wave_sqr = 2'd2,
        wave_off = 2'd3                // Silent output
    } wave_sel_e;

    // Bit layout of the voice control byte
    typedef struct packed {
        wave_sel_e wave_sel;           // Bits 7:6
        note_t     note;               // Bits 5:0
    } voice_ctrl_t;

    localparam int unsigned NOTES_PER_OCTAVE = 12;

    // Octave 0 divider thresholds from C to B
    localparam logic [31:0] base_threshold [NOTES_PER_OCTAVE] = '{
        32'd95786,                     // C
        32'd90180,                     // C#
        32'd85131,                     // D
        32'd80357,                     // D#
        32'd75758,                     // E
        32'd71586,                     // F
        32'd67567,                     // F#
        32'd63775,                     // G
        32'd60241,                     // G#
        32'd56818,                     // A
        32'd53763,                     // A#
        32'd50867                      // B
    };

endpackage

`default_nettype wire

/* hdl/envelope_pkg.sv */
// Envelope control types
`default_nettype none

package envelope_pkg;

    typedef struct packed {
        logic a;
        logic b;
    } quad_t;

    // One quadrature pair per knob
    typedef struct packed {
        quad_t attack;
        quad_t decay;
        quad_t sustain;
        quad_t rel;
    } knob_bus_t;

    typedef struct packed {
        logic [7:0] attack;            // Peak level
        logic [7:0] decay;             // Fall per step toward sustain
        logic [7:0] sustain;           // Hold level
        logic [7:0] rel;               // Fall per step toward zero
    } adsr_params_t;

    typedef enum logic [2:0] {
        st_idle,
        st_attack,
        st_decay,
        st_sustain,
        st_release
    } adsr_state_e;

endpackage

`default_nettype wire

/* hdl/note_divider.sv */
// Note step divider
`timescale 1ns/10ps
`default_nettype none

module note_divider import tone_pkg::*; #(
    parameter int RATE_SHIFT = 0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  note_t note,
    output logic  step
);

    note_t       note_eff;
    logic [3:0]  semitone;
    logic [2:0]  octave;
    logic [31:0] threshold;
    logic [31:0] count;

    // Notes past the table play A2
    assign note_eff  = (note >= 6'd60) ? 6'd33 : note;
    assign semitone  = 4'(note_eff % NOTES_PER_OCTAVE);
    assign octave    = 3'(note_eff / NOTES_PER_OCTAVE);
    assign threshold = base_threshold[semitone] >> (int'(octave) + RATE_SHIFT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            step  <= 1'b0;
        end else if (count >= threshold) begin  // Also catches a drop to a higher note
            count <= '0;
            step  <= 1'b1;
        end else begin
            count <= count + 32'd1;
            step  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/wave_bank.sv */
// Waveform phase generators
`timescale 1ns/10ps
`default_nettype none

module wave_bank import tone_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      step,
    input  wave_sel_e wave_sel,
    output sample_t   wave
);

    logic [7:0] tri_cnt;
    logic       tri_up;            // Triangle direction
    logic [7:0] saw_cnt;
    logic       sqr_level;

    // Triangle pauses one step at each end while it turns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tri_cnt <= 8'd0;
            tri_up  <= 1'b1;
        end else if (step) begin
            if (tri_up) begin
                if (tri_cnt < 8'd255) begin
                    tri_cnt <= tri_cnt + 8'd1;
                end else begin
                    tri_up <= 1'b0;
                end
            end else begin
                if (tri_cnt > 8'd0) begin
                    tri_cnt <= tri_cnt - 8'd1;
                end else begin
                    tri_up <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saw_cnt   <= 8'd0;
            sqr_level <= 1'b0;
        end else if (step) begin
            saw_cnt   <= saw_cnt + 8'd1;   // Wraps at 255
            sqr_level <= ~sqr_level;
        end
    end

    always_comb begin
        case (wave_sel)
            wave_tri: wave = tri_cnt;
            wave_saw: wave = saw_cnt;
            wave_sqr: wave = {8{sqr_level}};
            default:  wave = 8'd0;         // wave_off
        endcase
    end

endmodule

`default_nettype wire

/* hdl/quad_encoder.sv */
// Quadrature knob decoder
`timescale 1ns/10ps
`default_nettype none

module quad_encoder import envelope_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  quad_t      pins,
    output logic [7:0] value
);

    quad_t prev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev  <= '0;
            value <= 8'd0;
        end else begin
            prev <= pins;
            case ({pins.a, prev.a, pins.b, prev.b})
                4'b1000,                   // A rises, B low
                4'b0111: value <= value + 8'd1;  // A falls, B high
                4'b0010,                   // B rises, A low
                4'b1101: value <= value - 8'd1;  // B falls, A high
                default: value <= value;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/adsr_envelope.sv */
// ADSR envelope generator
`timescale 1ns/10ps
`default_nettype none

module adsr_envelope import envelope_pkg::*; #(
    parameter int HOLD_STEPS = 256
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         step,
    input  adsr_params_t params,
    output logic [7:0]   amplitude
);

    localparam int CNT_W = $clog2(HOLD_STEPS + 1);
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(HOLD_STEPS - 1);

    adsr_state_e      state;
    logic [CNT_W-1:0] hold_cnt;
    logic [7:0]       dec_amt;
    logic [7:0]       rel_amt;

    // A zero rate would stall, so it steps by one
    assign dec_amt = (params.decay == 8'd0) ? 8'd1 : params.decay;
    assign rel_amt = (params.rel == 8'd0) ? 8'd1 : params.rel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            hold_cnt  <= '0;
            amplitude <= 8'd0;
        end else if (step) begin
            case (state)
                st_idle: begin
                    if (hold_cnt == HOLD_LAST) begin
                        hold_cnt <= '0;
                        state    <= st_attack;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                st_attack: begin
                    if (amplitude < params.attack) begin
                        amplitude <= amplitude + 8'd1;
                    end else begin
                        state <= st_decay;
                    end
                end
                st_decay: begin
                    if (amplitude > params.sustain) begin
                        // Clamp so the fall stops at sustain
                        if (amplitude - params.sustain > dec_amt) begin
                            amplitude <= amplitude - dec_amt;
                        end else begin
                            amplitude <= params.sustain;
                        end
                    end else begin
                        state <= st_sustain;
                    end
                end
                st_sustain: begin
                    amplitude <= params.sustain;  // Follows the knob while held
                    if (hold_cnt == HOLD_LAST) begin
                        hold_cnt <= '0;
                        state    <= st_release;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                st_release: begin
                    if (amplitude > 8'd0) begin
                        amplitude <= (amplitude > rel_amt) ? amplitude - rel_amt : 8'd0;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/waves_synth.sv */
// Tone synthesizer top level
`timescale 1ns/10ps
`default_nettype none

module waves_synth import tone_pkg::*, envelope_pkg::*; #(
    parameter int RATE_SHIFT = 0,
    parameter int HOLD_STEPS = 256
) (
    input  logic        clk,
    input  logic        rst_n,
    input  voice_ctrl_t voice,
    input  knob_bus_t   knobs,
    output sample_t     sample,
    output logic [7:0]  env
);

    logic         step;
    sample_t      wave;
    adsr_params_t params;
    logic [15:0]  product;

    note_divider #(.RATE_SHIFT(RATE_SHIFT)) u_divider (
        .clk   (clk),
        .rst_n (rst_n),
        .note  (voice.note),
        .step  (step)
    );

    wave_bank u_waves (
        .clk      (clk),
        .rst_n    (rst_n),
        .step     (step),
        .wave_sel (voice.wave_sel),
        .wave     (wave)
    );

    quad_encoder u_knob_attack (
        .clk   (clk),
        .rst_n (rst_n),
        .pins  (knobs.attack),
        .value (params.attack)
    );

    quad_encoder u_knob_decay (
        .clk   (clk),
        .rst_n (rst_n),
        .pins  (knobs.decay),
        .value (params.decay)
    );

    quad_encoder u_knob_sustain (
        .clk   (clk),
        .rst_n (rst_n),
        .pins  (knobs.sustain),
        .value (params.sustain)
    );

    quad_encoder u_knob_release (
        .clk   (clk),
        .rst_n (rst_n),
        .pins  (knobs.rel),
        .value (params.rel)
    );

    adsr_envelope #(.HOLD_STEPS(HOLD_STEPS)) u_envelope (
        .clk       (clk),
        .rst_n     (rst_n),
        .step      (step),
        .params    (params),
        .amplitude (env)
    );

    // Gain stage keeps the upper byte of the product
    assign product = wave * env;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample <= 8'd0;
        end else begin
            sample <= product[15:8];
        end
    end

endmodule

`default_nettype wire

/* bench/waves_checker.sv */
// Tone generator checker
`timescale 1ns/10ps
`default_nettype none

module waves_checker import tone_pkg::*, envelope_pkg::*; #(
    parameter int RATE_SHIFT = 8,
    parameter int HOLD_STEPS = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  voice_ctrl_t voice,
    input  knob_bus_t   knobs,
    input  sample_t     sample,
    input  logic [7:0]  env,
    input  logic        dut_step,
    input  logic        row_end,
    input  int          row_idx,
    input  logic        peak_chk,
    input  logic [7:0]  exp_peak,
    output int          errors,
    output int          checks
);

    // Octave 0 periods from C to B
    localparam logic [31:0] ref_base [12] = '{
        32'd95786, 32'd90180, 32'd85131, 32'd80357, 32'd75758, 32'd71586,
        32'd67567, 32'd63775, 32'd60241, 32'd56818, 32'd53763, 32'd50867
    };

    logic [31:0] m_count;
    logic        m_step;
    logic [7:0]  m_tri;
    logic        m_tri_up;
    logic [7:0]  m_saw;
    logic        m_sqr;
    quad_t       m_prev [4];
    quad_t       pins [4];
    logic [7:0]  m_knob [4];           // Attack, decay, sustain, release
    adsr_state_e m_state;
    int          m_hold;
    logic [7:0]  m_amp;
    logic [7:0]  m_sample;
    logic [31:0] m_period;
    int          cyc;
    int          last_step_cyc;
    logic        gap_valid;
    int          row_err;
    logic [7:0]  row_peak;

    function automatic logic [31:0] note_period(input note_t n);
        int m;
        m = (n > 59) ? 33 : int'(n);
        return ref_base[m % 12] >> ((m / 12) + RATE_SHIFT);
    endfunction

    function automatic logic [7:0] quad_delta(input quad_t p, input quad_t c);
        if ((c.a && !p.a && !c.b && !p.b) || (!c.a && p.a && c.b && p.b)) begin
            return 8'd1;
        end
        if ((c.b && !p.b && !c.a && !p.a) || (!c.b && p.b && c.a && p.a)) begin
            return 8'hff;                  // Minus one modulo 256
        end
        return 8'd0;
    endfunction

    function automatic logic [7:0] pick_wave(input wave_sel_e s);
        case (s)
            wave_tri: return m_tri;
            wave_saw: return m_saw;
            wave_sqr: return m_sqr ? 8'd255 : 8'd0;
            default:  return 8'd0;
        endcase
    endfunction

    task automatic step_envelope();
        int a;
        int amt;
        case (m_state)
            st_idle: begin
                m_hold = m_hold + 1;
                if (m_hold == HOLD_STEPS) begin
                    m_hold  = 0;
                    m_state = st_attack;
                end
            end
            st_attack: begin
                if (m_amp < m_knob[0]) m_amp = m_amp + 8'd1;
                else m_state = st_decay;
            end
            st_decay: begin
                amt = (m_knob[1] == 0) ? 1 : int'(m_knob[1]);
                a   = int'(m_amp) - amt;
                if (m_amp > m_knob[2]) m_amp = (a < int'(m_knob[2])) ? m_knob[2] : 8'(a);
                else m_state = st_sustain;
            end
            st_sustain: begin
                m_amp  = m_knob[2];
                m_hold = m_hold + 1;
                if (m_hold == HOLD_STEPS) begin
                    m_hold  = 0;
                    m_state = st_release;
                end
            end
            default: begin
                amt = (m_knob[3] == 0) ? 1 : int'(m_knob[3]);
                a   = int'(m_amp) - amt;
                if (m_amp > 0) m_amp = (a < 0) ? 8'd0 : 8'(a);
                else m_state = st_idle;
            end
        endcase
    endtask

    task automatic report(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        errors  = errors + 1;
        row_err = row_err + 1;
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        row_err  = 0;
        row_peak = 8'd0;
        cyc      = 0;
    end

    // Cycle model advanced on each rising edge
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_count  = 0;
            m_step   = 0;
            m_tri    = 0;
            m_tri_up = 1;
            m_saw    = 0;
            m_sqr    = 0;
            m_state  = st_idle;
            m_hold   = 0;
            m_amp    = 0;
            m_sample = 0;
            for (int k = 0; k < 4; k++) begin
                m_prev[k] = '0;
                m_knob[k] = 8'd0;
            end
            gap_valid = 1'b0;
            m_period  = note_period(voice.note);
        end else begin
            m_sample = 8'((16'(pick_wave(voice.wave_sel)) * 16'(m_amp)) >> 8);
            if (m_step) begin
                step_envelope();
                if (m_tri_up) begin
                    if (m_tri == 8'd255) m_tri_up = 1'b0;
                    else m_tri = m_tri + 8'd1;
                end else begin
                    if (m_tri == 8'd0) m_tri_up = 1'b1;
                    else m_tri = m_tri - 8'd1;
                end
                m_saw = m_saw + 8'd1;
                m_sqr = ~m_sqr;
            end
            if (note_period(voice.note) != m_period) gap_valid = 1'b0;  // New note
            m_period = note_period(voice.note);
            if (m_count >= m_period) begin
                m_count = 0;
                m_step  = 1'b1;
            end else begin
                m_count = m_count + 1;
                m_step  = 1'b0;
            end
            pins[0] = knobs.attack;
            pins[1] = knobs.decay;
            pins[2] = knobs.sustain;
            pins[3] = knobs.rel;
            for (int k = 0; k < 4; k++) begin
                m_knob[k] = m_knob[k] + quad_delta(m_prev[k], pins[k]);
                m_prev[k] = pins[k];
            end
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            checks = checks + 1;
            cyc    = cyc + 1;
            if (sample !== m_sample) begin
                report($sformatf("sample %0d, expected %0d", sample, m_sample));
            end
            if (env !== m_amp) begin
                report($sformatf("env %0d, expected %0d", env, m_amp));
            end
            if (dut_step !== m_step) begin
                report($sformatf("step %0b, expected %0b", dut_step, m_step));
            end
            if (env > row_peak) row_peak = env;
            if (dut_step === 1'b1) begin
                if (gap_valid && (cyc - last_step_cyc) != int'(m_period) + 1) begin
                    report($sformatf("step spacing %0d, expected %0d",
                                     cyc - last_step_cyc, m_period + 1));
                end
                last_step_cyc = cyc;
                gap_valid     = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (row_end) begin
            if (peak_chk && row_peak !== exp_peak) begin
                report($sformatf("attack peak %0d, expected %0d", row_peak, exp_peak));
            end
            $display("Row %0d finished: %0d errors", row_idx, row_err);
            row_err  = 0;
            row_peak = 8'd0;
        end
    end

endmodule

`default_nettype wire

/* bench/waves_tb.sv */
// Tone generator testbench
`timescale 1ns/10ps
`default_nettype none

module waves_tb import tone_pkg::*, envelope_pkg::*;;

    typedef struct packed {
        voice_ctrl_t        voice;
        logic signed [15:0] t_att;     // Negative counts turn the knob back
        logic signed [15:0] t_dec;
        logic signed [15:0] t_sus;
        logic signed [15:0] t_rel;
        logic [15:0]        steps;
        logic               chk_peak;
    } row_t;

    localparam int NUM_ROWS = 6;

    logic        clk;
    logic        rst_n;
    voice_ctrl_t voice;
    knob_bus_t   knobs;
    sample_t     sample;
    logic [7:0]  env;
    logic        row_end;
    int          row_idx;
    logic        peak_chk;
    logic [7:0]  exp_peak;
    int          errors;
    int          checks;
    logic        timed_out;
    row_t        rows [NUM_ROWS];

    waves_synth #(.RATE_SHIFT(8), .HOLD_STEPS(16)) uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .voice  (voice),
        .knobs  (knobs),
        .sample (sample),
        .env    (env)
    );

    waves_checker #(.RATE_SHIFT(8), .HOLD_STEPS(16)) u_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .voice    (voice),
        .knobs    (knobs),
        .sample   (sample),
        .env      (env),
        .dut_step (uut.step),
        .row_end  (row_end),
        .row_idx  (row_idx),
        .peak_chk (peak_chk),
        .exp_peak (exp_peak),
        .errors   (errors),
        .checks   (checks)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic set_pins(input int idx, input quad_t q);
        case (idx)
            0: knobs.attack = q;
            1: knobs.decay = q;
            2: knobs.sustain = q;
            default: knobs.rel = q;
        endcase
    endtask

    // One full pin cycle per turn where pin a leads on a forward turn
    task automatic turn_knob(input int idx, input int count);
        quad_t fwd [4];
        quad_t rev [4];
        fwd = '{2'b10, 2'b11, 2'b01, 2'b00};
        rev = '{2'b01, 2'b11, 2'b10, 2'b00};
        for (int t = 0; t < ((count < 0) ? -count : count); t++) begin
            for (int p = 0; p < 4; p++) begin
                @(negedge clk);
                set_pins(idx, (count < 0) ? rev[p] : fwd[p]);
            end
        end
    endtask

    task automatic wait_steps(input int n);
        int waited;
        for (int s = 0; s < n && !timed_out; s++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (uut.step !== 1'b1 && waited < 2000);
            if (uut.step !== 1'b1) begin
                $display("Timed out waiting for a step pulse");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_env_zero();
        int waited;
        waited = 0;
        while (env !== 8'd0 && waited < 200000) begin
            @(negedge clk);
            waited++;
        end
        if (env !== 8'd0) begin
            $display("Timed out waiting for the envelope to reach zero");
            timed_out = 1'b1;
        end
    endtask

    initial begin
        rows[0] = '{'{wave_saw, 6'd0},  16'sd20,  16'sd0, 16'sd5, 16'sd2, 16'd40,  1'b0};
        rows[1] = '{'{wave_saw, 6'd33}, 16'sd0,   16'sd0, 16'sd0, 16'sd0, 16'd40,  1'b1};
        rows[2] = '{'{wave_saw, 6'd59}, 16'sd0,   16'sd0, 16'sd0, 16'sd0, 16'd150, 1'b0};
        rows[3] = '{'{wave_tri, 6'd62}, -16'sd30, 16'sd5, 16'sd3, 16'sd0, 16'd400, 1'b1};
        rows[4] = '{'{wave_sqr, 6'd59}, 16'sd0,   16'sd0, 16'sd0, 16'sd0, 16'd300, 1'b0};
        rows[5] = '{'{wave_off, 6'd12}, 16'sd2,   16'sd0, 16'sd0, 16'sd0, 16'd40,  1'b0};

        rst_n     = 1'b0;
        voice     = rows[0].voice;
        knobs     = '0;
        row_end   = 1'b0;
        row_idx   = 0;
        peak_chk  = 1'b0;
        exp_peak  = 8'd0;
        timed_out = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            @(negedge clk);
            voice = rows[r].voice;
            if (rows[r].t_att != 0 || rows[r].t_dec != 0 ||
                rows[r].t_sus != 0 || rows[r].t_rel != 0) begin
                wait_env_zero();          // Knobs move only while idle
                turn_knob(0, rows[r].t_att);
                turn_knob(1, rows[r].t_dec);
                turn_knob(2, rows[r].t_sus);
                turn_knob(3, rows[r].t_rel);
            end
            exp_peak = exp_peak + 8'(2 * rows[r].t_att);
            wait_steps(rows[r].steps);
            if (!timed_out) begin
                @(negedge clk);
                row_idx  = r;
                peak_chk = rows[r].chk_peak;
                row_end  = 1'b1;
                @(negedge clk);
                row_end = 1'b0;
            end
        end

        #10;
        $display("Rows: %0d, checks: %0d, errors: %0d", NUM_ROWS, checks, errors);
        if (timed_out) begin
            $display("The run stopped early on a timeout");
        end
        if (timed_out || errors != 0) begin
            $display("Testbench failed");
        end else begin
            $display("Testbench passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/tone_pkg.sv
hdl/envelope_pkg.sv
hdl/note_divider.sv
hdl/wave_bank.sv
hdl/quad_encoder.sv
hdl/adsr_envelope.sv
hdl/waves_synth.sv
bench/waves_checker.sv
bench/waves_tb.sv

/* Bender.yml */
package:
  name: waves_synth

sources:
  - hdl/tone_pkg.sv
  - hdl/envelope_pkg.sv
  - hdl/note_divider.sv
  - hdl/wave_bank.sv
  - hdl/quad_encoder.sv
  - hdl/adsr_envelope.sv
  - hdl/waves_synth.sv
  - target: test
    files:
      - bench/waves_checker.sv
      - bench/waves_tb.sv
